//--- design/cpuPkg.sv
package cpuPkg;

	localparam int wordWidth = 8;                  // Data and address width

	typedef logic [1:0] regAddrT;                  // Index into four registers
	typedef logic [wordWidth-1:0] wordT;           // Data word

	typedef enum logic [3:0] {
		opNop = 4'h0,
		opMov = 4'h1,                              // ra <- R[rb]
		opAdd = 4'h2,
		opSub = 4'h3,
		opAnd = 4'h4,
		opOr  = 4'h5,
		opOut = 4'h6,                              // Port <- R[rb]
		opIn  = 4'h7,                              // rb <- port
		opLdm = 4'h8,                              // rb <- imm
		opLdd = 4'h9,                              // rb <- M[imm]
		opStd = 4'ha                               // M[imm] <- R[rb]
	} opCodeT;

	typedef enum logic [1:0] {
		selAlu,
		selInput,
		selImm,
		selMem                                     // Filled in by memory stage
	} resultSelT;

	// Two-byte instructions carry an immediate in the following byte
	function automatic logic hasImm(opCodeT op);
		return (op == opLdm) || (op == opLdd) || (op == opStd);
	endfunction

	typedef struct packed {
		logic      regWrite;
		resultSelT resultSel;
		logic      memRead;
		logic      memWrite;
		logic      outEn;
	} ctrlT;

	typedef struct packed {
		logic valid;
		wordT instr;
		wordT imm;                                 // Byte after opcode
		wordT inSample;                            // Input port seen at fetch
	} fetchT;

	typedef struct packed {
		ctrlT    ctrl;
		opCodeT  op;
		regAddrT ra;
		regAddrT rb;
		regAddrT dest;
		wordT    operandA;
		wordT    operandB;
		wordT    imm;
		wordT    inSample;
	} idExT;

	typedef struct packed {
		ctrlT    ctrl;
		regAddrT dest;
		wordT    result;                           // Resolved stage result
		wordT    storeData;
		wordT    imm;                              // Also the memory address
	} exMemT;

	typedef struct packed {
		logic    writeEn;
		regAddrT dest;
		wordT    data;
	} wbT;

endpackage

//--- design/fetchStage.sv
module fetchStage (
	input  logic          clk,
	input  logic          arstN,
	input  logic          stall,
	input  cpuPkg::wordT  instr,
	input  cpuPkg::wordT  nextByte,
	input  cpuPkg::wordT  inPort,
	output cpuPkg::wordT  pc,
	output cpuPkg::fetchT ifId
);
	import cpuPkg::*;

	opCodeT fetchOp;                               // Opcode of byte at pc
	wordT   pcStep;

	assign fetchOp = opCodeT'(instr[7:4]);
	assign pcStep  = hasImm(fetchOp) ? wordT'(2) : wordT'(1); // Skip immediate byte

	// Program counter, wraps at 256
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= pc + pcStep;
		end
	end

	// IF/ID register, held during load-use stall
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ifId <= '0;                            // Invalid until first fetch
		end else if (!stall) begin
			ifId.valid    <= 1'b1;
			ifId.instr    <= instr;
			ifId.imm      <= nextByte;             // Unused by one-byte ops
			ifId.inSample <= inPort;
		end
	end

endmodule

//--- design/regFile.sv
module regFile (
	input  logic            clk,
	input  logic            arstN,
	input  cpuPkg::regAddrT readAddrA,
	input  cpuPkg::regAddrT readAddrB,
	input  cpuPkg::wbT      wb,
	output cpuPkg::wordT    readDataA,
	output cpuPkg::wordT    readDataB
);
	import cpuPkg::*;

	wordT regs [4];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.writeEn) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign readDataA = (wb.writeEn && wb.dest == readAddrA) ? wb.data : regs[readAddrA];
	assign readDataB = (wb.writeEn && wb.dest == readAddrB) ? wb.data : regs[readAddrB];

endmodule

//--- design/decodeStage.sv
module decodeStage (
	input  logic            clk,
	input  logic            arstN,
	input  cpuPkg::fetchT   ifId,
	input  cpuPkg::wordT    readDataA,
	input  cpuPkg::wordT    readDataB,
	output cpuPkg::regAddrT readAddrA,
	output cpuPkg::regAddrT readAddrB,
	output logic            stall,
	output cpuPkg::idExT    idEx
);
	import cpuPkg::*;

	opCodeT  op;
	regAddrT ra;
	regAddrT rb;
	regAddrT dest;
	ctrlT    ctrl;
	logic    useA;                                 // Instruction reads R[ra]
	logic    useB;                                 // Instruction reads R[rb]

	assign op = opCodeT'(ifId.instr[7:4]);
	assign ra = ifId.instr[3:2];
	assign rb = ifId.instr[1:0];

	assign readAddrA = ra;
	assign readAddrB = rb;

	// Control decode; unknown opcodes fall through as NOP
	always_comb begin
		ctrl = '0;
		dest = ra;
		useA = 1'b0;
		useB = 1'b0;
		case (op)
			opMov: begin
				ctrl.regWrite = 1'b1;
				useB = 1'b1;
			end
			opAdd, opSub, opAnd, opOr: begin
				ctrl.regWrite = 1'b1;
				useA = 1'b1;
				useB = 1'b1;
			end
			opOut: begin
				ctrl.outEn = 1'b1;
				useB = 1'b1;
			end
			opIn: begin
				ctrl.regWrite  = 1'b1;
				ctrl.resultSel = selInput;
				dest = rb;
			end
			opLdm: begin
				ctrl.regWrite  = 1'b1;
				ctrl.resultSel = selImm;
				dest = rb;
			end
			opLdd: begin
				ctrl.regWrite  = 1'b1;
				ctrl.resultSel = selMem;
				ctrl.memRead   = 1'b1;
				dest = rb;
			end
			opStd: begin
				ctrl.memWrite = 1'b1;
				useB = 1'b1;                       // Store data
			end
			default: ;
		endcase
		if (!ifId.valid) begin
			ctrl = '0;                             // Nothing fetched yet
		end
	end

	// Load-use: LDD in execute has no data until MEM
	assign stall = ifId.valid && idEx.ctrl.memRead &&
		((useA && idEx.dest == ra) || (useB && idEx.dest == rb));

	// ID/EX register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idEx <= '0;
		end else if (stall) begin
			idEx <= '0;                            // Bubble, all ctrl zero
		end else begin
			idEx.ctrl     <= ctrl;
			idEx.op       <= op;
			idEx.ra       <= ra;
			idEx.rb       <= rb;
			idEx.dest     <= dest;
			idEx.operandA <= readDataA;
			idEx.operandB <= readDataB;
			idEx.imm      <= ifId.imm;
			idEx.inSample <= ifId.inSample;
		end
	end

endmodule

//--- design/executeStage.sv
module executeStage (
	input  logic          clk,
	input  logic          arstN,
	input  cpuPkg::idExT  idEx,
	input  cpuPkg::wbT    wb,
	output cpuPkg::exMemT exMem
);
	import cpuPkg::*;

	logic fwdMemA;                                 // Newer producer hits ra
	logic fwdMemB;
	logic fwdWbA;                                  // Older producer hits ra
	logic fwdWbB;
	wordT opA;
	wordT opB;
	wordT aluOut;
	wordT result;

	assign fwdMemA = exMem.ctrl.regWrite && exMem.dest == idEx.ra;
	assign fwdMemB = exMem.ctrl.regWrite && exMem.dest == idEx.rb;
	assign fwdWbA  = wb.writeEn && wb.dest == idEx.ra;
	assign fwdWbB  = wb.writeEn && wb.dest == idEx.rb;

	// EX/MEM wins over MEM/WB, then the decoded register value
	assign opA = fwdMemA ? exMem.result : (fwdWbA ? wb.data : idEx.operandA);
	assign opB = fwdMemB ? exMem.result : (fwdWbB ? wb.data : idEx.operandB);

	always_comb begin
		case (idEx.op)
			opAdd:   aluOut = opA + opB;            // Modulo 256
			opSub:   aluOut = opA - opB;
			opAnd:   aluOut = opA & opB;
			opOr:    aluOut = opA | opB;
			default: aluOut = opB;                  // MOV and OUT pass rb
		endcase
	end

	// Result source; memory loads are swapped in one stage later
	always_comb begin
		case (idEx.ctrl.resultSel)
			selInput: result = idEx.inSample;
			selImm:   result = idEx.imm;
			default:  result = aluOut;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exMem <= '0;
		end else begin
			exMem.ctrl      <= idEx.ctrl;
			exMem.dest      <= idEx.dest;
			exMem.result    <= result;
			exMem.storeData <= opB;                 // Forwarded R[rb] for STD
			exMem.imm       <= idEx.imm;
		end
	end

endmodule

//--- design/memoryStage.sv
module memoryStage #(
	parameter int dataMemDepth = 256
) (
	input  logic          clk,
	input  logic          arstN,
	input  cpuPkg::exMemT exMem,
	output cpuPkg::wbT    wb,
	output cpuPkg::wordT  outPort,
	output logic          outEn
);
	import cpuPkg::*;

	localparam int addrBits = $clog2(dataMemDepth);

	wordT                dataMem [dataMemDepth];
	logic [addrBits-1:0] memAddr;
	wordT                loadData;
	wordT                memResult;

	assign memAddr = exMem.imm[addrBits-1:0];      // Truncated for small memories

	// Data memory, written on STD
	always_ff @(posedge clk) begin
		if (exMem.ctrl.memWrite) begin
			dataMem[memAddr] <= exMem.storeData;
		end
	end

	assign loadData  = dataMem[memAddr];
	assign memResult = exMem.ctrl.memRead ? loadData : exMem.result; // LDD takes memory byte

	// MEM/WB register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wb <= '0;
		end else begin
			wb.writeEn <= exMem.ctrl.regWrite;
			wb.dest    <= exMem.dest;
			wb.data    <= memResult;
		end
	end

	// Output port, updated as OUT enters writeback
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outPort <= '0;
			outEn   <= 1'b0;
		end else begin
			outEn <= exMem.ctrl.outEn;             // One-cycle pulse per OUT
			if (exMem.ctrl.outEn) begin
				outPort <= exMem.result;
			end
		end
	end

endmodule

//--- design/cpuTop.sv
module cpuTop #(
	parameter int dataMemDepth = 256
) (
	input  logic         clk,
	input  logic         arstN,
	input  cpuPkg::wordT instr,                    // Byte at pc
	input  cpuPkg::wordT nextByte,                 // Byte at pc+1
	input  cpuPkg::wordT inPort,
	output cpuPkg::wordT pc,
	output cpuPkg::wordT outPort,
	output logic         outEn
);
	import cpuPkg::*;

	fetchT   ifId;
	idExT    idEx;
	exMemT   exMem;
	wbT      wb;                                   // Writeback and older forward source
	regAddrT readAddrA;
	regAddrT readAddrB;
	wordT    readDataA;
	wordT    readDataB;
	logic    stall;                                // Load-use hold

	fetchStage uFetch (
		.clk      (clk),
		.arstN    (arstN),
		.stall    (stall),
		.instr    (instr),
		.nextByte (nextByte),
		.inPort   (inPort),
		.pc       (pc),
		.ifId     (ifId)
	);

	decodeStage uDecode (
		.clk       (clk),
		.arstN     (arstN),
		.ifId      (ifId),
		.readDataA (readDataA),
		.readDataB (readDataB),
		.readAddrA (readAddrA),
		.readAddrB (readAddrB),
		.stall     (stall),
		.idEx      (idEx)
	);

	regFile uRegFile (
		.clk       (clk),
		.arstN     (arstN),
		.readAddrA (readAddrA),
		.readAddrB (readAddrB),
		.wb        (wb),
		.readDataA (readDataA),
		.readDataB (readDataB)
	);

	executeStage uExecute (
		.clk   (clk),
		.arstN (arstN),
		.idEx  (idEx),
		.wb    (wb),
		.exMem (exMem)
	);

	memoryStage #(
		.dataMemDepth (dataMemDepth)
	) uMemory (
		.clk     (clk),
		.arstN   (arstN),
		.exMem   (exMem),
		.wb      (wb),
		.outPort (outPort),
		.outEn   (outEn)
	);

endmodule

//--- tests/cpuChecker.sv
module cpuChecker (
	input logic         clk,
	input logic         arstN,
	input cpuPkg::wordT outPort,
	input logic         outEn
);
	timeunit 1ns;
	timeprecision 100ps;
	import cpuPkg::*;

	wordT expQ [$];                                // Expected OUT values in order
	wordT expVal;
	logic firstSeen;                               // An OUT retired since reset
	int   mismatchCount = 0;
	int   otherCount = 0;

	function automatic void addExpected(wordT v);
		expQ.push_back(v);
	endfunction

	// Leftover entries mean outputs went missing
	function automatic void checkDrained(int p);
		if (expQ.size() != 0) begin
			$display("Program %0d ended with %0d expected outputs never produced",
				p, expQ.size());
			otherCount++;
			expQ.delete();
		end
	endfunction

	// Sampled on negedge while outputs are stable
	always @(negedge clk) begin
		if (!arstN) begin
			firstSeen = 1'b0;                      // Port must read 0 again
		end else if (outEn === 1'b1) begin
			firstSeen = 1'b1;
			if (expQ.size() == 0) begin
				$display("Unexpected outEn pulse at %0t with no output left to expect",
					$time);
				otherCount++;
			end else begin
				expVal = expQ.pop_front();
				if (outPort !== expVal) begin
					$display("FAIL %0t outPort expected %02h actual %02h",
						$time, expVal, outPort);
					mismatchCount++;
				end
			end
		end else if (outEn !== 1'b0) begin
			$display("outEn is unknown at %0t", $time);
			otherCount++;
		end else if (!firstSeen && outPort !== 8'h00) begin
			$display("FAIL %0t outPort expected 00 actual %02h", $time, outPort);
			mismatchCount++;
		end
	end

endmodule

//--- tests/cpuTb.sv
module cpuTb;
	timeunit 1ns;
	timeprecision 100ps;
	import cpuPkg::*;

	localparam int numProgs = 5;
	localparam int dataMemDepth = 256;             // Same depth as the DUT

	logic        clk = 1'b0;
	logic        arstN;
	wordT        inPort;
	wordT        pc;
	wordT        outPort;
	logic        outEn;
	wordT        imem [256];                       // Instruction memory at pc
	wordT        progs [numProgs][256];
	int          progLen [numProgs];               // Bytes before NOP padding
	wordT        stored [$];                       // STD addresses so far
	logic [31:0] lcgState = 32'hbe02_9019;
	int          cycleCount = 0;
	int          cycleLimit = 0;

	always #20 clk = ~clk;

	cpuTop #(
		.dataMemDepth (dataMemDepth)
	) u_dut (
		.clk      (clk),
		.arstN    (arstN),
		.instr    (imem[pc]),
		.nextByte (imem[8'(pc + 8'd1)]),           // Wraps like pc
		.inPort   (inPort),
		.pc       (pc),
		.outPort  (outPort),
		.outEn    (outEn)
	);

	cpuChecker uChecker (
		.clk     (clk),
		.arstN   (arstN),
		.outPort (outPort),
		.outEn   (outEn)
	);

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic void emit(int p, wordT b);
		progs[p][progLen[p]] = b;
		progLen[p]++;
	endfunction

	// Random program from an opcode mask that ends by outputting every register
	function automatic void buildProgram(int p, logic [15:0] opMask, int count,
		logic followStore);
		logic [31:0] r;
		logic [3:0]  op;
		wordT        imm;
		stored.delete();
		progLen[p] = 0;
		for (int i = 0; i < count && progLen[p] < 224; i++) begin
			do begin
				r  = nextRand();
				op = r[27:24];
			end while (!opMask[op]);
			if (op == opLdd && stored.size() == 0) begin
				op = opLdm;                        // Load only stored bytes
			end
			case (op)
				opLdm:   imm = r[23:16];
				opLdd:   imm = stored[r[23:16] % stored.size()];
				default: imm = {3'b000, r[12:8]};  // Small pool so addresses repeat
			endcase
			emit(p, {op, r[3:0]});
			if (op == opLdm || op == opLdd || op == opStd) begin
				emit(p, imm);
			end
			if (op == opStd) begin
				stored.push_back(imm);
			end
			if (op == opStd && followStore) begin
				emit(p, {opLdd, 2'b00, r[5:4]});   // Reload same address
				emit(p, imm);
				emit(p, {opAdd, r[5:4], r[5:4]});  // Immediate use forces load-use stall
				emit(p, {opOut, 2'b00, r[5:4]});
			end
		end
		for (int k = 0; k < 4; k++) begin
			emit(p, {opOut, 2'b00, 2'(k)});
		end
		for (int k = progLen[p]; k < 256; k++) begin
			progs[p][k] = 8'h00;                   // NOP padding
		end
	endfunction

	// Sequential model from zeroed registers
	function automatic void interpret(int p, wordT inVal);
		wordT       regs [4];
		wordT       dmem [dataMemDepth];
		wordT       ins;
		wordT       imm;
		logic [1:0] ra;
		logic [1:0] rb;
		int         pcRef;
		for (int k = 0; k < 4; k++) begin
			regs[k] = 8'h00;
		end
		pcRef = 0;
		while (pcRef < progLen[p]) begin
			ins = progs[p][pcRef];
			imm = progs[p][pcRef + 1];
			ra  = ins[3:2];
			rb  = ins[1:0];
			case (ins[7:4])
				opMov:   regs[ra] = regs[rb];
				opAdd:   regs[ra] = regs[ra] + regs[rb];
				opSub:   regs[ra] = regs[ra] - regs[rb];
				opAnd:   regs[ra] = regs[ra] & regs[rb];
				opOr:    regs[ra] = regs[ra] | regs[rb];
				opOut:   uChecker.addExpected(regs[rb]);
				opIn:    regs[rb] = inVal;
				opLdm:   regs[rb] = imm;
				opLdd:   regs[rb] = dmem[imm % dataMemDepth];
				opStd:   dmem[imm % dataMemDepth] = regs[rb];
				default: ;                         // NOP and unused codes
			endcase
			pcRef += (ins[7:4] == opLdm || ins[7:4] == opLdd || ins[7:4] == opStd) ? 2 : 1;
		end
	endfunction

	// Reset and load, then run until pc moves past the last byte
	task automatic runProgram(int p);
		logic [31:0] r;
		@(posedge clk);
		#1;
		arstN  = 1'b0;
		r      = nextRand();
		inPort = r[15:8];                          // Held for the whole program
		for (int a = 0; a < 256; a++) begin
			imem[a] = progs[p][a];
		end
		interpret(p, inPort);
		repeat (3) @(posedge clk);
		#1;
		arstN = 1'b1;
		while (pc < progLen[p]) begin
			@(negedge clk);                        // Last byte not fetched yet
		end
		repeat (8) @(posedge clk);                 // Last OUT drains, then room for stray outEn
		uChecker.checkDrained(p);
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit) begin
			$display("Timeout after %0d cycles, pc never moved past the program", cycleCount);
			$display("Errors: %0d value mismatches, %0d other failures",
				uChecker.mismatchCount, uChecker.otherCount);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		int total;
		arstN  = 1'b0;
		inPort = 8'h00;
		for (int a = 0; a < 256; a++) begin
			imem[a] = wordT'(a);                   // Defined bytes until the first load
		end
		buildProgram(0, 16'h017f, 40, 1'b0);       // ALU chains with LDM seeds
		buildProgram(1, 16'h0147, 40, 1'b0);       // LDM mixed with one-byte ops
		buildProgram(2, 16'h00ce, 30, 1'b0);       // IN with arithmetic
		buildProgram(3, 16'h0744, 30, 1'b1);       // STD then LDD
		buildProgram(4, 16'hffff, 200, 1'b0);      // Every opcode including unused codes
		total = 0;
		for (int p = 0; p < numProgs; p++) begin
			total += progLen[p];
		end
		cycleLimit = 2 * total + 20 * numProgs;
		for (int p = 0; p < numProgs; p++) begin
			runProgram(p);
		end
		$display("Errors: %0d value mismatches, %0d other failures",
			uChecker.mismatchCount, uChecker.otherCount);
		if (uChecker.mismatchCount + uChecker.otherCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- flist.f
design/cpuPkg.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/cpuTop.sv
tests/cpuChecker.sv
tests/cpuTb.sv

//--- Bender.yml
package:
  name: cpu8

sources:
  - files:
      - design/cpuPkg.sv
      - design/fetchStage.sv
      - design/regFile.sv
      - design/decodeStage.sv
      - design/executeStage.sv
      - design/memoryStage.sv
      - design/cpuTop.sv
  - target: test
    files:
      - tests/cpuChecker.sv
      - tests/cpuTb.sv
